//--- design/resampler_macros.svh
`ifndef RESAMPLER_MACROS_SVH
`define RESAMPLER_MACROS_SVH

// Channels per frame
`define RS_CH_NUM 2

// Sample and coefficient widths
`define RS_DATA_WIDTH 16
`define RS_COEF_WIDTH 18

// Filter length
`define RS_TAP_NUM 8

// Product width plus 3 guard bits for the 8-term sum
`define RS_ACC_WIDTH (`RS_DATA_WIDTH + `RS_COEF_WIDTH + 3)

// Interpolation and decimation factor width
`define RS_RATE_WIDTH 4

`define RS_FIFO_DEPTH 4

`endif

//--- design/resampler_pkg.sv
`include "resampler_macros.svh"

package resampler_pkg;

    typedef logic signed [`RS_DATA_WIDTH-1:0] sample_t;
    typedef logic signed [`RS_COEF_WIDTH-1:0] coef_t;
    typedef logic signed [`RS_ACC_WIDTH-1:0]  acc_t;

    typedef sample_t [`RS_CH_NUM-1:0] sample_frame_t;
    typedef acc_t    [`RS_CH_NUM-1:0] acc_frame_t;

    typedef logic [`RS_RATE_WIDTH-1:0] rate_t;

    // Upsampler to filter
    typedef struct packed {
        logic          valid;
        sample_frame_t data;
    } sample_beat_t;

    // Filter to decimator
    typedef struct packed {
        logic       valid;
        acc_frame_t data;
    } acc_beat_t;

    // Low-pass taps where index 0 multiplies the newest sample
    localparam coef_t COEF_TABLE [`RS_TAP_NUM] = '{
        18'sd2048, 18'sd9216, 18'sd24576, 18'sd31744,
        18'sd20480, 18'sd6144, -18'sd3072, -18'sd1536
    };

endpackage

//--- design/frame_fifo.sv
`timescale 1ns/10ps
`include "resampler_macros.svh"

module frame_fifo (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         wr_valid_i,
    output logic                         wr_ready_o,
    input  resampler_pkg::sample_frame_t wr_data_i,
    output logic                         rd_valid_o,
    input  logic                         rd_ready_i,
    output resampler_pkg::sample_frame_t rd_data_o
);

    import resampler_pkg::*;

    localparam int DEPTH = `RS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    sample_frame_t    mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             wr_ready_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = wr_valid_i && wr_ready_q;
    assign pop  = rd_valid_o && rd_ready_i;

    assign count_d = count_q + CNT_W'(push) - CNT_W'(pop);

    assign wr_ready_o = wr_ready_q;
    assign rd_valid_o = (count_q != '0);
    // Head frame is visible without a read request
    assign rd_data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            wr_ready_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q    <= count_d;
            // Ready follows the occupancy of the next cycle
            wr_ready_q <= (count_d != CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule

//--- design/upsampler.sv
`timescale 1ns/10ps

module upsampler (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         en_i,
    input  resampler_pkg::rate_t         interp_i,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  resampler_pkg::sample_frame_t in_data_i,
    output resampler_pkg::sample_beat_t  beat_o
);

    import resampler_pkg::*;

    typedef enum logic {
        IDLE   = 1'b0,
        INTERP = 1'b1
    } state_e;

    state_e        state_q;
    rate_t         phase_q;
    rate_t         last_phase;
    logic          pop;
    logic          valid_q;
    sample_frame_t data_q;

    assign in_ready_o = en_i && (state_q == IDLE);
    assign pop        = in_valid_i && in_ready_o;
    assign last_phase = interp_i - rate_t'(1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            phase_q <= '0;
            valid_q <= 1'b0;
        end else if (en_i) begin
            unique case (state_q)
                IDLE: begin
                    valid_q <= pop;
                    // With L of 1 every frame is a single beat
                    if (pop && (interp_i != rate_t'(1))) begin
                        state_q <= INTERP;
                        phase_q <= rate_t'(1);
                    end
                end
                INTERP: begin
                    valid_q <= 1'b1;
                    if (phase_q == last_phase) begin
                        state_q <= IDLE;
                        phase_q <= '0;
                    end else begin
                        phase_q <= phase_q + rate_t'(1);
                    end
                end
            endcase
        end
    end

    // Data beat first, then zero frames
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (pop) begin
                data_q <= in_data_i;
            end else if (state_q == INTERP) begin
                data_q <= '0;
            end
        end
    end

    assign beat_o = '{valid: valid_q, data: data_q};

endmodule

//--- design/fir_filter.sv
`timescale 1ns/10ps
`include "resampler_macros.svh"

module fir_filter (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        en_i,
    input  resampler_pkg::sample_beat_t beat_i,
    output resampler_pkg::acc_beat_t    beat_o
);

    import resampler_pkg::*;

    localparam int CH   = `RS_CH_NUM;
    localparam int TAPS = `RS_TAP_NUM;

    // Older samples with index 0 as the previous beat
    sample_t    hist_q [CH][TAPS-1];
    // Full filter window including the incoming sample
    sample_t    win    [CH][TAPS];
    acc_frame_t acc_d;
    acc_frame_t acc_q;
    logic       valid_q;
    logic       shift;

    assign shift = en_i && beat_i.valid;

    always_comb begin
        for (int ch = 0; ch < CH; ch++) begin
            win[ch][0] = beat_i.data[ch];
            for (int k = 1; k < TAPS; k++) begin
                win[ch][k] = hist_q[ch][k-1];
            end
        end
    end

    always_comb begin
        acc_t sum;
        for (int ch = 0; ch < CH; ch++) begin
            sum = '0;
            for (int k = 0; k < TAPS; k++) begin
                // Signed multiply widened to the accumulator
                sum = sum + win[ch][k] * COEF_TABLE[k];
            end
            acc_d[ch] = sum;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int ch = 0; ch < CH; ch++) begin
                for (int k = 0; k < TAPS - 1; k++) begin
                    hist_q[ch][k] <= '0;
                end
            end
        end else if (shift) begin
            for (int ch = 0; ch < CH; ch++) begin
                hist_q[ch][0] <= beat_i.data[ch];
                for (int k = 1; k < TAPS - 1; k++) begin
                    hist_q[ch][k] <= hist_q[ch][k-1];
                end
            end
        end
    end

    // Valid holds while disabled so the decimator sees each beat once
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (en_i) begin
            valid_q <= beat_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (shift) begin
            acc_q <= acc_d;
        end
    end

    assign beat_o = '{valid: valid_q, data: acc_q};

endmodule

//--- design/decimator.sv
`timescale 1ns/10ps

module decimator (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      en_i,
    input  resampler_pkg::rate_t      decim_i,
    input  resampler_pkg::acc_beat_t  beat_i,
    output logic                      tvalid_o,
    output resampler_pkg::acc_frame_t tdata_o
);

    import resampler_pkg::*;

    rate_t      phase_q;
    rate_t      last_phase;
    logic       keep;
    logic       valid_q;
    acc_frame_t data_q;

    assign last_phase = decim_i - rate_t'(1);
    // First beat after reset is kept
    assign keep       = beat_i.valid && (phase_q == '0);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            phase_q <= '0;
            valid_q <= 1'b0;
        end else if (en_i) begin
            valid_q <= keep;
            if (beat_i.valid) begin
                if (phase_q == last_phase) begin
                    phase_q <= '0;
                end else begin
                    phase_q <= phase_q + rate_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && keep) begin
            data_q <= beat_i.data;
        end
    end

    // A result pending across a disabled span shows once enable returns
    assign tvalid_o = valid_q && en_i;
    assign tdata_o  = data_q;

endmodule

//--- design/resampler_top.sv
`timescale 1ns/10ps

module resampler_top (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         en_i,
    input  resampler_pkg::rate_t         interp_i,
    input  resampler_pkg::rate_t         decim_i,
    input  logic                         s_tvalid_i,
    output logic                         s_tready_o,
    input  resampler_pkg::sample_frame_t s_tdata_i,
    output logic                         m_tvalid_o,
    output resampler_pkg::acc_frame_t    m_tdata_o
);

    import resampler_pkg::*;

    logic          fifo_valid;
    logic          fifo_ready;
    sample_frame_t fifo_data;
    sample_beat_t  up_beat;
    acc_beat_t     fir_beat;

    // Input bursts wait here while the upsampler is busy
    frame_fifo i_frame_fifo (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .wr_valid_i(s_tvalid_i),
        .wr_ready_o(s_tready_o),
        .wr_data_i (s_tdata_i),
        .rd_valid_o(fifo_valid),
        .rd_ready_i(fifo_ready),
        .rd_data_o (fifo_data)
    );

    upsampler i_upsampler (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .en_i      (en_i),
        .interp_i  (interp_i),
        .in_valid_i(fifo_valid),
        .in_ready_o(fifo_ready),
        .in_data_i (fifo_data),
        .beat_o    (up_beat)
    );

    fir_filter i_fir_filter (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .en_i  (en_i),
        .beat_i(up_beat),
        .beat_o(fir_beat)
    );

    decimator i_decimator (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .en_i    (en_i),
        .decim_i (decim_i),
        .beat_i  (fir_beat),
        .tvalid_o(m_tvalid_o),
        .tdata_o (m_tdata_o)
    );

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 2
) (
    input  logic rst_req_i,
    output logic clk_o,
    output logic rstn_o
);

    int unsigned hold_cnt;

    initial begin
        clk_o    = 1'b0;
        rstn_o   = 1'b0;
        hold_cnt = RESET_CYCLES - 1;
    end

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

    // Request is sampled on the rising edge
    always @(posedge clk_o) begin
        if (rst_req_i) begin
            hold_cnt = RESET_CYCLES;
        end
    end

    // Reset moves on the falling edge away from the DUT sampling edge
    always @(negedge clk_o) begin
        if (hold_cnt != 0) begin
            rstn_o   = 1'b0;
            hold_cnt = hold_cnt - 1;
        end else begin
            rstn_o = 1'b1;
        end
    end

endmodule

//--- tb/tb_resampler.sv
`timescale 1ns/10ps
`include "resampler_macros.svh"

module tb_resampler;

    import resampler_pkg::*;

    typedef struct packed {
        rate_t      interp;
        rate_t      decim;
        logic [7:0] frames;
        logic       impulse;
        logic       burst;
        logic       pulses;
    } test_case_t;

    localparam int NUM_CASES     = 7;
    localparam int IDLE_CYCLES   = 16;
    localparam int CASE_OVERHEAD = 40;

    // L, M, frames, impulse, continuous burst, enable pulses
    localparam test_case_t CASES [NUM_CASES] = '{
        '{4'd1,  4'd1, 8'd12, 1'b1, 1'b0, 1'b0},
        '{4'd3,  4'd1, 8'd6,  1'b0, 1'b0, 1'b0},
        '{4'd1,  4'd2, 8'd12, 1'b0, 1'b0, 1'b0},
        '{4'd3,  4'd2, 8'd10, 1'b0, 1'b0, 1'b0},
        '{4'd5,  4'd2, 8'd12, 1'b0, 1'b1, 1'b0},
        '{4'd2,  4'd3, 8'd16, 1'b0, 1'b0, 1'b1},
        '{4'd15, 4'd7, 8'd4,  1'b0, 1'b0, 1'b0}
    };

    logic          clk_i;
    logic          rstn_i;
    logic          rst_req;
    logic          en_i;
    rate_t         interp_i;
    rate_t         decim_i;
    logic          s_tvalid_i;
    logic          s_tready_o;
    sample_frame_t s_tdata_i;
    logic          m_tvalid_o;
    acc_frame_t    m_tdata_o;

    sample_frame_t stim_q [$];
    acc_frame_t    exp_q [$];
    acc_frame_t    exp_frame;
    logic          ready_low_seen;
    logic          case_done;

    tb_clk_gen #(
        .PERIOD_NS   (8.0),
        .RESET_CYCLES(2)
    ) i_clk_gen (
        .rst_req_i(rst_req),
        .clk_o    (clk_i),
        .rstn_o   (rstn_i)
    );

    resampler_top DUT (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .en_i      (en_i),
        .interp_i  (interp_i),
        .decim_i   (decim_i),
        .s_tvalid_i(s_tvalid_i),
        .s_tready_o(s_tready_o),
        .s_tdata_i (s_tdata_i),
        .m_tvalid_o(m_tvalid_o),
        .m_tdata_o (m_tdata_o)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] %s: actual 0x%0h, expected 0x%0h",
                                        name, actual, expected));
        end
    endtask

    function automatic int unsigned watchdog_cycles();
        int unsigned total;
        total = 0;
        foreach (CASES[i]) begin
            total += CASES[i].frames * CASES[i].interp * 40 + CASE_OVERHEAD;
        end
        return total;
    endfunction

    task automatic apply_reset();
        @(negedge clk_i);
        rst_req = 1'b1;
        @(negedge clk_i);
        rst_req = 1'b0;
        @(negedge clk_i);
        check_value("s_tready_o", s_tready_o, 1'b0);
        check_value("m_tvalid_o", m_tvalid_o, 1'b0);
        @(negedge clk_i);
        @(negedge clk_i);
        check_value("m_tvalid_o", m_tvalid_o, 1'b0);
    endtask

    task automatic make_frames(input int n, input logic impulse);
        sample_frame_t frame;
        stim_q.delete();
        for (int f = 0; f < n; f++) begin
            for (int ch = 0; ch < `RS_CH_NUM; ch++) begin
                if (impulse) begin
                    frame[ch] = (f == 0 && ch == 0) ? sample_t'(1) : sample_t'(0);
                end else begin
                    frame[ch] = sample_t'($urandom);
                end
            end
            stim_q.push_back(frame);
        end
    endtask

    // Zero-stuff by L, convolve per channel, keep every M-th result from the first
    task automatic build_expected(input int l, input int m);
        longint     hist [`RS_CH_NUM][`RS_TAP_NUM];
        longint     sum;
        acc_frame_t result;
        int         idx;
        exp_q.delete();
        idx = 0;
        foreach (hist[ch, k]) begin
            hist[ch][k] = 0;
        end
        foreach (stim_q[f]) begin
            for (int p = 0; p < l; p++) begin
                for (int ch = 0; ch < `RS_CH_NUM; ch++) begin
                    for (int k = `RS_TAP_NUM - 1; k > 0; k--) begin
                        hist[ch][k] = hist[ch][k-1];
                    end
                    hist[ch][0] = (p == 0) ? longint'(stim_q[f][ch]) : 0;
                end
                if (idx % m == 0) begin
                    for (int ch = 0; ch < `RS_CH_NUM; ch++) begin
                        sum = 0;
                        for (int k = 0; k < `RS_TAP_NUM; k++) begin
                            sum += hist[ch][k] * longint'(COEF_TABLE[k]);
                        end
                        result[ch] = acc_t'(sum);
                    end
                    exp_q.push_back(result);
                end
                idx++;
            end
        end
    endtask

    task automatic drive_frames(input logic burst);
        logic ready_now;
        int   gap;
        foreach (stim_q[i]) begin
            s_tvalid_i = 1'b1;
            s_tdata_i  = stim_q[i];
            // Ready is registered, so its value now holds at the next rising edge
            ready_now  = s_tready_o;
            while (!ready_now) begin
                ready_low_seen = 1'b1;
                @(negedge clk_i);
                ready_now = s_tready_o;
            end
            @(negedge clk_i);
            gap = burst ? 0 : int'($urandom % 3);
            if (gap != 0) begin
                s_tvalid_i = 1'b0;
                repeat (gap) @(negedge clk_i);
            end
        end
        s_tvalid_i = 1'b0;
    endtask

    task automatic pulse_enable();
        int span;
        while (!case_done) begin
            @(negedge clk_i);
            if ($urandom % 5 == 0) begin
                span = 1 + int'($urandom % 6);
                en_i = 1'b0;
                repeat (span) @(negedge clk_i);
                en_i = 1'b1;
            end
        end
    endtask

    // Output monitor
    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (!en_i) begin
                check_value("m_tvalid_o", m_tvalid_o, 1'b0);
            end
            if (m_tvalid_o) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("Output frame arrived with no result left to expect");
                end else begin
                    exp_frame = exp_q.pop_front();
                    for (int ch = 0; ch < `RS_CH_NUM; ch++) begin
                        check_value($sformatf("m_tdata_o[%0d]", ch), m_tdata_o[ch],
                                    exp_frame[ch]);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int unsigned limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk_i);
        stop_with_failure("Watchdog expired because the output stopped before all results came");
    end

    initial begin
        void'($urandom(86));
        rst_req    = 1'b0;
        en_i       = 1'b1;
        interp_i   = rate_t'(1);
        decim_i    = rate_t'(1);
        s_tvalid_i = 1'b0;
        s_tdata_i  = '0;
        case_done  = 1'b0;

        foreach (CASES[i]) begin
            interp_i       = CASES[i].interp;
            decim_i        = CASES[i].decim;
            ready_low_seen = 1'b0;
            case_done      = 1'b0;
            make_frames(CASES[i].frames, CASES[i].impulse);
            build_expected(CASES[i].interp, CASES[i].decim);
            apply_reset();

            fork
                begin
                    drive_frames(CASES[i].burst);
                    while (exp_q.size() != 0) @(negedge clk_i);
                    case_done = 1'b1;
                end
                begin
                    if (CASES[i].pulses) begin
                        pulse_enable();
                    end
                end
            join
            en_i = 1'b1;

            // Any extra output in this window has nothing left to match
            repeat (IDLE_CYCLES) @(negedge clk_i);
            if (CASES[i].burst) begin
                check_value("s_tready_o low during burst", ready_low_seen, 1'b1);
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+design
design/resampler_pkg.sv
design/frame_fifo.sv
design/upsampler.sv
design/fir_filter.sv
design/decimator.sv
design/resampler_top.sv
tb/tb_clk_gen.sv
tb/tb_resampler.sv
